// ==== vlog.f ====
design/l2_pkg.sv
design/l2_bank_if.sv
design/l2_bank.sv
design/l2_data_store.sv
design/l2_data_top.sv
tb/tb_clock.sv
tb/l2_data_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= l2_data_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the regression, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/l2_data_tb.sv ====
// directed tests of the data array; the scoreboard only models lines that the tests fully write
module l2_data_tb import l2_pkg::*; ();

  localparam int TEST_BEATS      = 140;
  localparam int WATCHDOG_CYCLES = 40 * TEST_BEATS + 500;
  localparam int DRAIN_LIMIT     = 200;

  localparam line_addr_t LINE_A = {17'h00a5, 9'd37};
  localparam line_addr_t LINE_B = {17'h1c40, 9'd37};
  localparam line_addr_t LINE_C = {17'h0333, 9'd200};
  localparam line_addr_t LINE_D = {17'h1f00, 9'd311};

  logic clk, rst;
  logic req_valid, req_cmd_valid, req_wen, req_ready;
  l2_cmd_e req_cmd, bus_req_cmd;
  beat_addr_t req_addr;
  way_oh_t req_way, snoop_way;
  logic [7:0] req_wmask;
  logic [DATA_W-1:0] req_wdata, snoop_wdata, bus_req_data, bus_snoop_data, resp_rdata;
  logic snoop_valid, snoop_wen, snoop_ready;
  snoop_tag_t snoop_tag, bus_snoop_tag;
  line_addr_t snoop_addr, inv_addr, bus_req_addr, bus_snoop_addr;
  logic inv_valid, flush_hit;
  logic bus_req_valid, bus_req_ready, bus_snoop_valid, bus_snoop_ready;
  logic resp_valid, resp_ready;

  // expected line contents per way, set and beat
  logic [DATA_W-1:0] sb [NUM_WAYS][512][BEATS];
  logic [31:0] lfsr;
  int errors, passed, failed;

  tb_clock u_clock (.clk(clk), .rst(rst));

  l2_data_top u_l2_data_top (.*);

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = next_bit();
    end
    return v;
  endfunction

  task automatic mismatch(input string what, input logic [63:0] got, input logic [63:0] exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic flag_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name, input int e0);
    if (errors == e0) begin
      passed++;
      $display("test %s done, no errors", name);
    end else begin
      failed++;
      $display("test %s done, %0d errors", name, errors - e0);
    end
  endtask

  task automatic set_req(input logic cmdv, input l2_cmd_e cmd, input line_addr_t la,
                         input logic [2:0] beat, input int w, input logic wen,
                         input logic [7:0] mask, input logic [DATA_W-1:0] data);
    req_valid     = 1'b1;
    req_cmd_valid = cmdv;
    req_cmd       = cmd;
    req_addr      = {la, beat};
    req_way       = way_oh_t'(1 << w);
    req_wen       = wen;
    req_wmask     = mask;
    req_wdata     = data;
  endtask

  // ready is checked mid-cycle and the transfer happens on the next edge
  task automatic accept_req();
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic set_snoop(input int w, input line_addr_t la, input snoop_tag_t tag,
                           input logic wen);
    snoop_valid = 1'b1;
    snoop_tag   = tag;
    snoop_addr  = la;
    snoop_way   = way_oh_t'(1 << w);
    snoop_wen   = wen;
  endtask

  task automatic accept_snoop();
    @(negedge clk);
    while (!snoop_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    snoop_valid = 1'b0;
  endtask

  task automatic write_beat(input int w, input line_addr_t la, input logic [2:0] beat,
                            input logic [7:0] mask, input logic [DATA_W-1:0] data);
    set_req(1'b0, CMD_BUSRD, la, beat, w, 1'b1, mask, data);
    accept_req();
    for (int i = 0; i < 8; i++) begin
      if (mask[i]) begin
        sb[w][la[14:6]][beat][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic fill_line(input int w, input line_addr_t la);
    for (int b = 0; b < BEATS; b++) begin
      write_beat(w, la, 3'(b), 8'hff, rand_bits(64));
    end
  endtask

  // collects snoop and response beats; responses must wait for the whole snoop burst
  task automatic drain(input int sw, input line_addr_t sla, input snoop_tag_t stag,
                       input int n_snoop, input int rw, input line_addr_t rla,
                       input int n_resp, input logic toggle);
    int s_got, r_got, cyc;
    s_got = 0;
    r_got = 0;
    cyc = 0;
    while ((s_got < n_snoop || r_got < n_resp) && cyc < DRAIN_LIMIT) begin
      @(negedge clk);
      if (resp_valid && resp_ready) begin
        if (r_got >= n_resp) begin
          flag_error("response beat that no read asked for");
        end else begin
          if (s_got < n_snoop) begin
            flag_error("response beat arrived before the snoop burst finished");
          end
          if (resp_rdata !== sb[rw][rla[14:6]][r_got]) begin
            mismatch($sformatf("resp beat %0d", r_got), resp_rdata, sb[rw][rla[14:6]][r_got]);
          end
        end
        r_got++;
      end
      if (bus_snoop_valid) begin
        if (s_got >= n_snoop) begin
          flag_error("snoop beat that no snoop read asked for");
        end else begin
          if (bus_snoop_tag !== stag) begin
            mismatch("snoop tag", 64'(bus_snoop_tag), 64'(stag));
          end
          if (bus_snoop_addr !== sla) begin
            mismatch("snoop addr", 64'(bus_snoop_addr), 64'(sla));
          end
          if (bus_snoop_data !== sb[sw][sla[14:6]][s_got]) begin
            mismatch($sformatf("snoop beat %0d", s_got), bus_snoop_data,
                     sb[sw][sla[14:6]][s_got]);
          end
        end
        s_got++;
      end
      @(posedge clk);
      #1;
      if (toggle) begin
        resp_ready = next_bit();
      end
      cyc++;
    end
    resp_ready = 1'b1;
    if (s_got < n_snoop || r_got < n_resp) begin
      flag_error($sformatf("only %0d snoop and %0d response beats arrived", s_got, r_got));
    end
    @(negedge clk);
    if (bus_snoop_valid || resp_valid) begin
      flag_error("extra beat after the burst ended");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic read_line(input int w, input line_addr_t la, input logic toggle);
    set_req(1'b0, CMD_BUSRD, la, 3'd0, w, 1'b0, 8'h00, '0);
    accept_req();
    drain(0, '0, '0, 0, w, la, BEATS, toggle);
  endtask

  task automatic snoop_write(input int w, input line_addr_t la, input snoop_tag_t tag);
    for (int k = 0; k < BEATS; k++) begin
      sb[w][la[14:6]][k] = rand_bits(64);
    end
    set_snoop(w, la, tag, 1'b1);
    snoop_wdata = sb[w][la[14:6]][0];
    accept_snoop();
    // beat k is sampled k edges after acceptance
    for (int k = 1; k < BEATS; k++) begin
      snoop_wdata = sb[w][la[14:6]][k];
      @(posedge clk);
      #1;
    end
  endtask

  task automatic flush_line(input int w, input line_addr_t la, input int hold);
    int got, cyc;
    inv_addr = la;
    bus_req_ready = (hold == 0);
    @(negedge clk);
    if (flush_hit) begin
      flag_error("flush_hit high before the flush was sent");
    end
    @(posedge clk);
    #1;
    set_req(1'b1, CMD_FLUSH, la, 3'd0, w, 1'b0, 8'h00, '0);
    accept_req();
    got = 0;
    cyc = 0;
    while (got < BEATS && cyc < DRAIN_LIMIT) begin
      @(negedge clk);
      if (!flush_hit) begin
        flag_error("flush_hit low while the flush is in flight");
      end
      if (bus_req_valid) begin
        // beat 0 needs two edges after bus_req_ready rises
        if (cyc <= hold + 1) begin
          flag_error("flush beat sent before bus_req_ready let the burst start");
        end
        if (bus_req_cmd !== CMD_FLUSH) begin
          mismatch("flush cmd", 64'(bus_req_cmd), 64'(CMD_FLUSH));
        end
        if (bus_req_addr !== la) begin
          mismatch("flush addr", 64'(bus_req_addr), 64'(la));
        end
        if (bus_req_data !== sb[w][la[14:6]][got]) begin
          mismatch($sformatf("flush beat %0d", got), bus_req_data, sb[w][la[14:6]][got]);
        end
        got++;
      end
      @(posedge clk);
      #1;
      cyc++;
      if (cyc == hold) begin
        bus_req_ready = 1'b1;
      end
    end
    bus_req_ready = 1'b1;
    if (got < BEATS) begin
      flag_error($sformatf("flush produced only %0d bus beats", got));
    end
    @(negedge clk);
    if (flush_hit || bus_req_valid) begin
      flag_error("flush still visible after its last beat");
    end
    @(posedge clk);
    #1;
  endtask

  // a single-beat command; the window is long enough to catch a second beat
  task automatic send_cmd(input l2_cmd_e cmd, input line_addr_t la, input logic match,
                          input l2_cmd_e exp_cmd);
    int got;
    inv_valid = 1'b1;
    inv_addr  = match ? la : la ^ line_addr_t'(1);
    set_req(1'b1, cmd, la, 3'd5, 1, 1'b0, 8'h00, '0);
    accept_req();
    got = 0;
    repeat (8) begin
      @(negedge clk);
      if (bus_req_valid) begin
        if (bus_req_cmd !== exp_cmd) begin
          mismatch($sformatf("%s bus cmd", cmd.name()), 64'(bus_req_cmd), 64'(exp_cmd));
        end
        if (bus_req_addr !== la) begin
          mismatch("bus addr", 64'(bus_req_addr), 64'(la));
        end
        got++;
      end
      @(posedge clk);
      #1;
    end
    inv_valid = 1'b0;
    if (got != 1) begin
      flag_error($sformatf("%s gave %0d bus beats instead of one", cmd.name(), got));
    end
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    if (!req_ready || !snoop_ready) begin
      flag_error("ready outputs low after reset");
    end
    if (resp_valid || bus_req_valid || bus_snoop_valid || flush_hit) begin
      flag_error("valid output or flush_hit high after reset");
    end
    @(posedge clk);
    #1;
    end_test("reset state", e0);
  endtask

  task automatic masked_write_read();
    int e0;
    e0 = errors;
    // same set in two ways
    fill_line(0, LINE_A);
    fill_line(3, LINE_B);
    repeat (6) begin
      write_beat(0, LINE_A, 3'(rand_bits(3)), 8'(rand_bits(8)), rand_bits(64));
      write_beat(3, LINE_B, 3'(rand_bits(3)), 8'(rand_bits(8)), rand_bits(64));
    end
    read_line(0, LINE_A, 1'b0);
    read_line(3, LINE_B, 1'b0);
    end_test("masked write and read", e0);
  endtask

  task automatic flush_burst();
    int e0;
    e0 = errors;
    fill_line(1, LINE_C);
    flush_line(1, LINE_C, 0);
    end_test("flush", e0);
  endtask

  task automatic upgrade_convert();
    int e0;
    e0 = errors;
    send_cmd(CMD_BUSUPGR, LINE_C, 1'b1, CMD_BUSRDX);
    send_cmd(CMD_BUSUPGR, LINE_C, 1'b0, CMD_BUSUPGR);
    send_cmd(CMD_BUSRD, LINE_A, 1'b1, CMD_BUSRD);
    end_test("upgrade conversion", e0);
  endtask

  task automatic snoop_roundtrip();
    int e0;
    e0 = errors;
    snoop_write(2, LINE_D, 5'h13);
    set_snoop(2, LINE_D, 5'h0b, 1'b0);
    accept_snoop();
    drain(2, LINE_D, 5'h0b, BEATS, 0, '0, 0, 1'b0);
    read_line(2, LINE_D, 1'b0);
    end_test("snoop write and read", e0);
  endtask

  task automatic backpressure();
    int e0;
    e0 = errors;
    read_line(0, LINE_A, 1'b1);
    flush_line(1, LINE_C, 5);
    end_test("back-pressure", e0);
  endtask

  task automatic snoop_priority();
    int e0;
    e0 = errors;
    set_req(1'b0, CMD_BUSRD, LINE_B, 3'd0, 3, 1'b0, 8'h00, '0);
    set_snoop(2, LINE_D, 5'h07, 1'b0);
    @(negedge clk);
    if (!req_ready || !snoop_ready) begin
      flag_error("request and snoop not both accepted in the same cycle");
    end
    @(posedge clk);
    #1;
    req_valid   = 1'b0;
    snoop_valid = 1'b0;
    drain(2, LINE_D, 5'h07, BEATS, 3, LINE_B, BEATS, 1'b0);
    end_test("snoop priority", e0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin
    lfsr = 32'hdfcd;
    errors = 0;
    passed = 0;
    failed = 0;
    req_valid = 1'b0;
    req_cmd_valid = 1'b0;
    req_cmd = CMD_BUSRD;
    req_addr = '0;
    req_way = 4'b0001;
    req_wen = 1'b0;
    req_wmask = 8'h00;
    req_wdata = '0;
    snoop_valid = 1'b0;
    snoop_tag = '0;
    snoop_addr = '0;
    snoop_way = 4'b0001;
    snoop_wen = 1'b0;
    snoop_wdata = '0;
    inv_valid = 1'b0;
    inv_addr = '0;
    bus_req_ready = 1'b1;
    bus_snoop_ready = 1'b1;
    resp_ready = 1'b1;
    @(negedge rst);
    @(posedge clk);
    #1;
    reset_state();
    masked_write_read();
    flush_burst();
    upgrade_convert();
    snoop_roundtrip();
    backpressure();
    snoop_priority();
    $display("%0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clock.sv ====
// free-running clock of period 10; rst is held high for the first 5 rising edges
module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 5;
  localparam int RST_CYCLES  = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

// ==== design/l2_data_top.sv ====
// data array subsystem; tag lookup and transaction engine sit outside and connect through these plain ports
module l2_data_top import l2_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // request
  input  logic              req_valid,
  input  logic              req_cmd_valid,
  input  l2_cmd_e           req_cmd,
  input  beat_addr_t        req_addr,
  input  way_oh_t           req_way,
  input  logic              req_wen,
  input  logic [7:0]        req_wmask,
  input  logic [DATA_W-1:0] req_wdata,
  output logic              req_ready,
  // snoop
  input  logic              snoop_valid,
  input  snoop_tag_t        snoop_tag,
  input  line_addr_t        snoop_addr,
  input  way_oh_t           snoop_way,
  input  logic              snoop_wen,
  input  logic [DATA_W-1:0] snoop_wdata,
  output logic              snoop_ready,
  // invalidate
  input  logic              inv_valid,
  input  line_addr_t        inv_addr,
  output logic              flush_hit,
  // transaction-side bus
  output logic              bus_req_valid,
  output l2_cmd_e           bus_req_cmd,
  output line_addr_t        bus_req_addr,
  output logic [DATA_W-1:0] bus_req_data,
  input  logic              bus_req_ready,
  output logic              bus_snoop_valid,
  output snoop_tag_t        bus_snoop_tag,
  output line_addr_t        bus_snoop_addr,
  output logic [DATA_W-1:0] bus_snoop_data,
  input  logic              bus_snoop_ready,
  // response
  output logic              resp_valid,
  output logic [DATA_W-1:0] resp_rdata,
  input  logic              resp_ready
);

  l2_bank_if bank_if [NUM_BANKS] ();

  l2_data_store u_store (
    .*,
    .banks (bank_if)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    l2_bank u_bank (
      .clk  (clk),
      .rst  (rst),
      .bank (bank_if[i])
    );
  end

endmodule

// ==== design/l2_data_store.sv ====
// snoops always win the banks and never stall; a snoop read to a bank whose data sits in a stalled response overwrites it
module l2_data_store import l2_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // tag-side request
  input  logic              req_valid,
  input  logic              req_cmd_valid,
  input  l2_cmd_e           req_cmd,
  input  beat_addr_t        req_addr,
  input  way_oh_t           req_way,
  input  logic              req_wen,
  input  logic [7:0]        req_wmask,
  input  logic [DATA_W-1:0] req_wdata,
  output logic              req_ready,
  // tag-side snoop
  input  logic              snoop_valid,
  input  snoop_tag_t        snoop_tag,
  input  line_addr_t        snoop_addr,
  input  way_oh_t           snoop_way,
  input  logic              snoop_wen,
  input  logic [DATA_W-1:0] snoop_wdata,
  output logic              snoop_ready,
  input  logic              inv_valid,
  input  line_addr_t        inv_addr,
  output logic              flush_hit,
  // transaction side
  output logic              bus_req_valid,
  output l2_cmd_e           bus_req_cmd,
  output line_addr_t        bus_req_addr,
  output logic [DATA_W-1:0] bus_req_data,
  input  logic              bus_req_ready,
  output logic              bus_snoop_valid,
  output snoop_tag_t        bus_snoop_tag,
  output line_addr_t        bus_snoop_addr,
  output logic [DATA_W-1:0] bus_snoop_data,
  input  logic              bus_snoop_ready,
  // response
  output logic              resp_valid,
  output logic [DATA_W-1:0] resp_rdata,
  input  logic              resp_ready,
  l2_bank_if.ctrl           banks [NUM_BANKS]
);

  function automatic logic [1:0] oh2idx(input logic [3:0] oh);
    oh2idx = {oh[2] | oh[3], oh[1] | oh[3]};
  endfunction

  // s0 request
  logic              s0_req_valid_r;
  logic              s0_req_cmd_valid_r;
  l2_cmd_e           s0_req_cmd_r;
  beat_addr_t        s0_req_addr_r;
  way_oh_t           s0_req_way_r;
  logic              s0_req_wen_r;
  logic [7:0]        s0_req_wmask_r;
  logic [DATA_W-1:0] s0_req_wdata_r;
  logic [2:0]        s0_req_beat_r;

  // s0 snoop
  logic              s0_snoop_valid_r;
  snoop_tag_t        s0_snoop_tag_r;
  line_addr_t        s0_snoop_addr_r;
  way_oh_t           s0_snoop_way_r;
  logic              s0_snoop_wen_r;
  logic [DATA_W-1:0] s0_snoop_wdata_r;
  logic [2:0]        s0_snoop_beat_r;

  // s1/s2 shadows
  logic                 s1_req_valid_r, s2_req_valid_r;
  logic                 s1_req_cmd_valid_r, s2_req_cmd_valid_r;
  l2_cmd_e              s1_req_cmd_r, s2_req_cmd_r;
  line_addr_t           s1_req_addr_r, s2_req_addr_r;
  logic [NUM_BANKS-1:0] s1_req_bank_r, s2_req_bank_r;
  logic                 s1_snoop_valid_r, s2_snoop_valid_r;
  snoop_tag_t           s1_snoop_tag_r, s2_snoop_tag_r;
  line_addr_t           s1_snoop_addr_r, s2_snoop_addr_r;
  logic [NUM_BANKS-1:0] s1_snoop_bank_r, s2_snoop_bank_r;

  // bank steering
  logic [NUM_BANKS-1:0] bank_valid;
  logic [BANK_AW-1:0]   bank_addr;
  logic                 bank_wen;
  logic [7:0]           bank_wmask;
  logic [DATA_W-1:0]    bank_wdata;
  logic [DATA_W-1:0]    bank_rdata [NUM_BANKS];

  logic                 req_burst, req_bank_access, req_to_pipe;
  logic [1:0]           req_bank_idx;
  logic                 req_half;
  logic [NUM_BANKS-1:0] req_bank_sel, snoop_bank_sel;
  logic [BANK_AW-1:0]   req_bank_addr, snoop_bank_addr;
  logic                 resp_stall, req_issue, snoop_issue;
  logic                 req_last, snoop_last;
  logic                 s0_match, s1_match, s2_match;
  logic                 s0_upgr_hit, s1_upgr_hit, s2_upgr_hit;

  // reads without a command and flushes walk all eight beats
  assign req_burst = s0_req_cmd_valid_r ? (s0_req_cmd_r == CMD_FLUSH) : ~s0_req_wen_r;
  assign req_bank_access = ~s0_req_cmd_valid_r | req_burst;
  assign req_to_pipe = s0_req_cmd_valid_r | ~s0_req_wen_r;

  assign req_bank_idx = req_burst ? s0_req_beat_r[1:0] : s0_req_addr_r[4:3];
  assign req_half = req_burst ? s0_req_beat_r[2] : s0_req_addr_r[5];
  assign req_bank_sel = NUM_BANKS'(1) << req_bank_idx;
  assign snoop_bank_sel = NUM_BANKS'(1) << s0_snoop_beat_r[1:0];
  assign req_bank_addr = {oh2idx(s0_req_way_r), s0_req_addr_r[14:6], req_half};
  assign snoop_bank_addr = {oh2idx(s0_snoop_way_r), s0_snoop_addr_r[14:6], s0_snoop_beat_r[2]};

  assign req_last = (s0_req_beat_r == 3'(BEATS - 1));
  assign snoop_last = (s0_snoop_beat_r == 3'(BEATS - 1));

  assign resp_stall = resp_valid & ~resp_ready;

  // bus ready only gates beat 0
  assign snoop_issue = s0_snoop_valid_r &
                       (s0_snoop_wen_r | bus_snoop_ready | (s0_snoop_beat_r != 3'd0));
  assign req_issue = s0_req_valid_r & ~snoop_issue & (~resp_stall | ~req_to_pipe) &
                     (~s0_req_cmd_valid_r | bus_req_ready | (s0_req_beat_r != 3'd0));

  assign req_ready = ~s0_req_valid_r | ((~req_burst | req_last) & req_issue);
  assign snoop_ready = ~s0_snoop_valid_r | (snoop_last & snoop_issue);

  // invalidate compare per stage
  assign s0_match = s0_req_valid_r & s0_req_cmd_valid_r & (s0_req_addr_r[31:6] == inv_addr);
  assign s1_match = s1_req_valid_r & s1_req_cmd_valid_r & (s1_req_addr_r == inv_addr);
  assign s2_match = s2_req_valid_r & s2_req_cmd_valid_r & (s2_req_addr_r == inv_addr);

  assign flush_hit = (s0_match & (s0_req_cmd_r == CMD_FLUSH)) |
                     (s1_match & (s1_req_cmd_r == CMD_FLUSH)) |
                     (s2_match & (s2_req_cmd_r == CMD_FLUSH));

  assign s0_upgr_hit = inv_valid & s0_match & (s0_req_cmd_r == CMD_BUSUPGR);
  assign s1_upgr_hit = inv_valid & s1_match & (s1_req_cmd_r == CMD_BUSUPGR);
  assign s2_upgr_hit = inv_valid & s2_match & (s2_req_cmd_r == CMD_BUSUPGR);

  always_comb begin
    bank_valid = '0;
    bank_addr  = snoop_bank_addr;
    bank_wen   = s0_snoop_wen_r;
    bank_wmask = 8'hff;
    bank_wdata = s0_snoop_wdata_r;
    if (snoop_issue) begin
      bank_valid = snoop_bank_sel;
    end else if (req_issue) begin
      // plain commands pass through without a bank access
      bank_valid = req_bank_access ? req_bank_sel : '0;
      bank_addr  = req_bank_addr;
      bank_wen   = s0_req_wen_r & ~s0_req_cmd_valid_r;
      bank_wmask = s0_req_wmask_r;
      bank_wdata = s0_req_wdata_r;
    end
  end

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    assign banks[i].valid = bank_valid[i];
    assign banks[i].wen   = bank_wen;
    assign banks[i].addr  = bank_addr;
    assign banks[i].wmask = bank_wmask;
    assign banks[i].wdata = bank_wdata;
    assign bank_rdata[i]  = banks[i].rdata;
  end

  assign resp_valid = s2_req_valid_r & ~s2_req_cmd_valid_r;
  assign resp_rdata = bank_rdata[oh2idx(s2_req_bank_r)];

  assign bus_req_valid = s2_req_valid_r & s2_req_cmd_valid_r;
  assign bus_req_cmd   = s2_upgr_hit ? CMD_BUSRDX : s2_req_cmd_r;
  assign bus_req_addr  = s2_req_addr_r;
  assign bus_req_data  = bank_rdata[oh2idx(s2_req_bank_r)];

  assign bus_snoop_valid = s2_snoop_valid_r;
  assign bus_snoop_tag   = s2_snoop_tag_r;
  assign bus_snoop_addr  = s2_snoop_addr_r;
  assign bus_snoop_data  = bank_rdata[oh2idx(s2_snoop_bank_r)];

  always_ff @(posedge clk) begin
    if (rst) begin
      s0_req_valid_r   <= 1'b0;
      s0_req_beat_r    <= 3'd0;
      s0_snoop_valid_r <= 1'b0;
      s0_snoop_beat_r  <= 3'd0;
    end else begin
      if (req_ready) begin
        s0_req_valid_r <= req_valid;
      end
      if (req_issue && req_burst) begin
        s0_req_beat_r <= s0_req_beat_r + 3'd1;
      end
      if (snoop_ready) begin
        s0_snoop_valid_r <= snoop_valid;
      end
      if (snoop_issue) begin
        s0_snoop_beat_r <= s0_snoop_beat_r + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready && req_valid) begin
      s0_req_cmd_valid_r <= req_cmd_valid;
      s0_req_cmd_r       <= req_cmd;
      s0_req_addr_r      <= req_addr;
      s0_req_way_r       <= req_way;
      s0_req_wen_r       <= req_wen;
      s0_req_wmask_r     <= req_wmask;
      s0_req_wdata_r     <= req_wdata;
    end else if (s0_upgr_hit) begin
      s0_req_cmd_r <= CMD_BUSRDX;
    end
    if (snoop_ready && snoop_valid) begin
      s0_snoop_tag_r  <= snoop_tag;
      s0_snoop_addr_r <= snoop_addr;
      s0_snoop_way_r  <= snoop_way;
      s0_snoop_wen_r  <= snoop_wen;
    end
    // snoop write data streams in one beat per cycle
    s0_snoop_wdata_r <= snoop_wdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_req_valid_r   <= 1'b0;
      s2_req_valid_r   <= 1'b0;
      s1_snoop_valid_r <= 1'b0;
      s2_snoop_valid_r <= 1'b0;
    end else begin
      if (!resp_stall) begin
        s1_req_valid_r <= req_issue & req_to_pipe;
        s2_req_valid_r <= s1_req_valid_r;
      end
      s1_snoop_valid_r <= snoop_issue & ~s0_snoop_wen_r;
      s2_snoop_valid_r <= s1_snoop_valid_r;
    end
  end

  // held stages keep converting upgrades
  always_ff @(posedge clk) begin
    if (!resp_stall && req_issue && req_to_pipe) begin
      s1_req_cmd_valid_r <= s0_req_cmd_valid_r;
      s1_req_cmd_r       <= s0_upgr_hit ? CMD_BUSRDX : s0_req_cmd_r;
      s1_req_addr_r      <= s0_req_addr_r[31:6];
      s1_req_bank_r      <= req_bank_sel;
    end else if (s1_upgr_hit) begin
      s1_req_cmd_r <= CMD_BUSRDX;
    end
    if (!resp_stall && s1_req_valid_r) begin
      s2_req_cmd_valid_r <= s1_req_cmd_valid_r;
      s2_req_cmd_r       <= s1_upgr_hit ? CMD_BUSRDX : s1_req_cmd_r;
      s2_req_addr_r      <= s1_req_addr_r;
      s2_req_bank_r      <= s1_req_bank_r;
    end else if (s2_upgr_hit) begin
      s2_req_cmd_r <= CMD_BUSRDX;
    end
  end

  always_ff @(posedge clk) begin
    if (snoop_issue && !s0_snoop_wen_r) begin
      s1_snoop_tag_r  <= s0_snoop_tag_r;
      s1_snoop_addr_r <= s0_snoop_addr_r;
      s1_snoop_bank_r <= snoop_bank_sel;
    end
    if (s1_snoop_valid_r) begin
      s2_snoop_tag_r  <= s1_snoop_tag_r;
      s2_snoop_addr_r <= s1_snoop_addr_r;
      s2_snoop_bank_r <= s1_snoop_bank_r;
    end
  end

  a_req_way_oh: assert property (@(posedge clk) disable iff (rst)
    (req_valid && req_ready) |-> $onehot(req_way));

  a_snoop_way_oh: assert property (@(posedge clk) disable iff (rst)
    (snoop_valid && snoop_ready) |-> $onehot(snoop_way));

  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    $onehot0(bank_valid));

  a_out_excl: assert property (@(posedge clk) disable iff (rst)
    !(resp_valid && bus_req_valid));

endmodule

// ==== design/l2_bank.sv ====
// single-port bank of 4096 x 64 bits; read data is valid two edges after the strobe and is not reset
module l2_bank import l2_pkg::*; (
  input logic     clk,
  input logic     rst,
  l2_bank_if.bank bank
);

  logic [DATA_W-1:0]  mem [1 << BANK_AW];
  logic [BANK_AW-1:0] rd_addr_r;
  logic               rd_pend_r;
  logic [DATA_W-1:0]  rdata_r;

  // byte-masked write
  always_ff @(posedge clk) begin
    if (bank.valid && bank.wen) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (bank.wmask[b]) begin
          mem[bank.addr][b*8 +: 8] <= bank.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend_r <= 1'b0;
    end else begin
      rd_pend_r <= bank.valid & ~bank.wen;
    end
  end

  // address stage, then data stage
  always_ff @(posedge clk) begin
    if (bank.valid && !bank.wen) begin
      rd_addr_r <= bank.addr;
    end
    if (rd_pend_r) begin
      rdata_r <= mem[rd_addr_r];
    end
  end

  assign bank.rdata = rdata_r;

  a_addr_known: assert property (@(posedge clk) disable iff (rst)
    bank.valid |-> !$isunknown(bank.addr));

endmodule

// ==== design/l2_bank_if.sv ====
// one bank port of the data array; valid is a one-cycle strobe with no handshake, rdata holds until the next read
interface l2_bank_if import l2_pkg::*; ();

  logic               valid;
  logic               wen;
  logic [BANK_AW-1:0] addr;
  logic [7:0]         wmask;
  logic [DATA_W-1:0]  wdata;
  logic [DATA_W-1:0]  rdata;

  // pipeline side
  modport ctrl (
    output valid, wen, addr, wmask, wdata,
    input  rdata
  );

  // sram side
  modport bank (
    input  valid, wen, addr, wmask, wdata,
    output rdata
  );

endinterface

// ==== design/l2_pkg.sv ====
// fixed geometry of 4 ways x 512 sets x 64-byte lines over 4 banks; command codes must match the tag and transaction sides
package l2_pkg;

  // array geometry
  localparam int NUM_BANKS = 4;
  localparam int NUM_WAYS  = 4;
  localparam int BEATS     = 8;
  localparam int DATA_W    = 64;

  // bank row is {way, set[14:6], half}
  localparam int BANK_AW   = 12;

  // bus commands toward the transaction side
  typedef enum logic [2:0] {
    CMD_BUSRD   = 3'd0,
    CMD_BUSRDX  = 3'd1,
    CMD_BUSUPGR = 3'd2,
    CMD_FLUSH   = 3'd3,
    CMD_WB      = 3'd4
  } l2_cmd_e;

  // address bits [31:6] of a line
  typedef logic [31:6] line_addr_t;

  // address bits [31:3] of a beat
  typedef logic [31:3] beat_addr_t;

  // one-hot way select from the tag lookup
  typedef logic [NUM_WAYS-1:0] way_oh_t;

  typedef logic [4:0] snoop_tag_t;

endpackage
